// ==== src/nes_io_pkg.sv ====
package nes_io_pkg;

  // number of players behind the two ports
  localparam int PAD_COUNT = 4;

  // third byte on each port while the four-player adapter is on
  localparam logic [7:0] MULTITAP_SIG_PORT1 = 8'h08;
  localparam logic [7:0] MULTITAP_SIG_PORT2 = 8'h04;

  // 64 entries of three bytes each
  localparam int PAL_BYTES = 192;
  localparam int DL_ADDR_W = 28;

  // raw inputs of one player
  typedef struct packed {
    logic a;
    logic b;
    logic a_turbo;
    logic b_turbo;
    logic start;
    logic select;
    logic up;
    logic down;
    logic left;
    logic right;
  } pad_buttons_t;

  // entry 0 is player 1
  typedef pad_buttons_t [PAD_COUNT-1:0] pad_array_t;

  // console pad report, a goes out first
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } nes_report_t;

  // byte 0 sits in the low bits and is shifted out first
  typedef nes_report_t [2:0] port_frame_t;

  // frames per turbo half-period, minus one
  typedef logic [2:0] turbo_speed_t;

  typedef struct packed {
    logic [5:0] index;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } pal_entry_t;

endpackage

// ==== src/button_turbo.sv ====
`timescale 1ns/1ns

module button_turbo import nes_io_pkg::*; (
  input  logic         clk_ppu_21_47,
  input  logic         reset_nes,
  input  turbo_speed_t turbo_speed,
  input  logic         vsync,
  input  logic         a_turbo_held,
  input  logic         b_turbo_held,
  output logic         a_turbo,
  output logic         b_turbo
);

  logic         vsync_q;
  logic         frame_start;
  turbo_speed_t frame_count;
  logic         phase;

  // one pulse per frame
  assign frame_start = vsync & ~vsync_q;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      vsync_q     <= 1'b0;
      frame_count <= '0;
      phase       <= 1'b0;
    end else begin
      vsync_q <= vsync;
      if (frame_start) begin
        // half-period done, flip the phase
        if (frame_count == turbo_speed) begin
          frame_count <= '0;
          phase       <= ~phase;
        end else begin
          frame_count <= frame_count + 3'd1;
        end
      end
    end
  end

  // held turbo buttons follow the phase
  assign a_turbo = a_turbo_held & phase;
  assign b_turbo = b_turbo_held & phase;

endmodule

// ==== src/joypad_port.sv ====
`timescale 1ns/1ns

module joypad_port import nes_io_pkg::*; (
  input  logic        clk_ppu_21_47,
  input  logic        reset_nes,
  input  logic        joypad_strobe,
  input  logic        shift_clock,
  input  port_frame_t frame,
  output logic        data
);

  logic [23:0] shift_reg;
  logic        shift_clock_q;
  logic        clock_fall;

  // previous sample high and the input low now
  assign clock_fall = shift_clock_q & ~shift_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      shift_reg     <= '0;
      shift_clock_q <= 1'b0;
    end else begin
      shift_clock_q <= shift_clock;
      // shift wins over a load in the same cycle
      if (clock_fall) begin
        shift_reg <= {1'b0, shift_reg[23:1]};
      end else if (joypad_strobe) begin
        shift_reg <= frame;
      end
    end
  end

  // zeros fill in from the top, so the line reads 0 once all bits are out
  assign data = shift_reg[0];

endmodule

// ==== src/controller_hub.sv ====
`timescale 1ns/1ns

module controller_hub import nes_io_pkg::*; (
  input  logic         clk_ppu_21_47,
  input  logic         reset_nes,
  input  pad_array_t   pads,
  input  turbo_speed_t turbo_speed,
  input  logic         vsync,
  input  logic         swap_controllers,
  input  logic         multitap_enabled,
  input  logic         joypad_strobe,
  input  logic [1:0]   joypad_clock,
  output logic         joypad1_data,
  output logic         joypad2_data
);

  logic        [PAD_COUNT-1:0] a_turbo;
  logic        [PAD_COUNT-1:0] b_turbo;
  nes_report_t [PAD_COUNT-1:0] reports;
  port_frame_t                 frame1;
  port_frame_t                 frame2;

  for (genvar i = 0; i < PAD_COUNT; i++) begin : g_player
    button_turbo u_turbo (
      .clk_ppu_21_47(clk_ppu_21_47),
      .reset_nes    (reset_nes),
      .turbo_speed  (turbo_speed),
      .vsync        (vsync),
      .a_turbo_held (pads[i].a_turbo),
      .b_turbo_held (pads[i].b_turbo),
      .a_turbo      (a_turbo[i]),
      .b_turbo      (b_turbo[i])
    );

    // turbo only adds presses on top of the plain buttons
    assign reports[i] = '{
      right:  pads[i].right,
      left:   pads[i].left,
      down:   pads[i].down,
      up:     pads[i].up,
      start:  pads[i].start,
      select: pads[i].select,
      b:      pads[i].b | b_turbo[i],
      a:      pads[i].a | a_turbo[i]
    };
  end

  always_comb begin
    frame1[0] = swap_controllers ? reports[1] : reports[0];
    frame2[0] = swap_controllers ? reports[0] : reports[1];
    if (multitap_enabled) begin
      // players 3 and 4 stay on their ports even when swapped
      frame1[1] = reports[2];
      frame1[2] = nes_report_t'(MULTITAP_SIG_PORT1);
      frame2[1] = reports[3];
      frame2[2] = nes_report_t'(MULTITAP_SIG_PORT2);
    end else begin
      // a lone pad reads all ones past its own byte
      frame1[2:1] = '1;
      frame2[2:1] = '1;
    end
  end

  joypad_port u_port1 (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .joypad_strobe(joypad_strobe),
    .shift_clock  (joypad_clock[0]),
    .frame        (frame1),
    .data         (joypad1_data)
  );

  joypad_port u_port2 (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .joypad_strobe(joypad_strobe),
    .shift_clock  (joypad_clock[1]),
    .frame        (frame2),
    .data         (joypad2_data)
  );

endmodule

// ==== src/palette_loader.sv ====
`timescale 1ns/1ns

module palette_loader import nes_io_pkg::*; (
  input  logic                 clk_ppu_21_47,
  input  logic                 reset_nes,
  input  logic                 palette_download,
  input  logic                 ioctl_wr,
  input  logic [DL_ADDR_W-1:0] ioctl_addr,
  input  logic [7:0]           ioctl_dout,
  output logic                 pal_write,
  output pal_entry_t           pal_entry
);

  logic [1:0] pal_count;
  logic [5:0] pal_index;
  logic [7:0] red_q;
  logic [7:0] green_q;
  logic [7:0] blue_q;
  logic       byte_valid;

  // bytes past the palette area are dropped
  assign byte_valid = palette_download & ioctl_wr &
                      (ioctl_addr < DL_ADDR_W'(PAL_BYTES));

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes || !palette_download) begin
      pal_count <= 2'd0;
      pal_index <= '0;
    end else if (byte_valid) begin
      pal_count <= (pal_count == 2'd2) ? 2'd0 : pal_count + 2'd1;
      // first byte of every entry but the very first moves the index on
      if (pal_count == 2'd0 && ioctl_addr != '0) begin
        pal_index <= pal_index + 6'd1;
      end
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (byte_valid) begin
      case (pal_count)
        2'd0: red_q <= ioctl_dout;
        2'd1: green_q <= ioctl_dout;
        2'd2: blue_q <= ioctl_dout;
        default: ;
      endcase
    end
  end

  // high between entries, so it rises once the blue byte is in
  assign pal_write = palette_download & (pal_count == 2'd0);

  assign pal_entry = '{
    index: pal_index,
    red:   red_q,
    green: green_q,
    blue:  blue_q
  };

endmodule

// ==== src/nes_io_top.sv ====
`timescale 1ns/1ns

module nes_io_top import nes_io_pkg::*; (
  input  logic                 clk_ppu_21_47,
  input  logic                 reset_nes,

  // pads and their options
  input  pad_array_t           pads,
  input  turbo_speed_t         turbo_speed,
  input  logic                 vsync,
  input  logic                 swap_controllers,
  input  logic                 multitap_enabled,

  // console side of the two ports
  input  logic                 joypad_strobe,
  input  logic [1:0]           joypad_clock,
  output logic                 joypad1_data,
  output logic                 joypad2_data,

  // palette download
  input  logic                 palette_download,
  input  logic                 ioctl_wr,
  input  logic [DL_ADDR_W-1:0] ioctl_addr,
  input  logic [7:0]           ioctl_dout,
  output logic                 pal_write,
  output pal_entry_t           pal_entry
);

  controller_hub u_controller_hub (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .pads            (pads),
    .turbo_speed     (turbo_speed),
    .vsync           (vsync),
    .swap_controllers(swap_controllers),
    .multitap_enabled(multitap_enabled),
    .joypad_strobe   (joypad_strobe),
    .joypad_clock    (joypad_clock),
    .joypad1_data    (joypad1_data),
    .joypad2_data    (joypad2_data)
  );

  palette_loader u_palette_loader (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .palette_download(palette_download),
    .ioctl_wr        (ioctl_wr),
    .ioctl_addr      (ioctl_addr),
    .ioctl_dout      (ioctl_dout),
    .pal_write       (pal_write),
    .pal_entry       (pal_entry)
  );

endmodule

// ==== tb/nes_io_sva.sv ====
`timescale 1ns/1ns

module nes_io_sva import nes_io_pkg::*; (
  input logic                 clk_ppu_21_47,
  input logic                 reset_nes,
  input logic                 palette_download,
  input logic                 ioctl_wr,
  input logic [DL_ADDR_W-1:0] ioctl_addr,
  input logic                 joypad1_data,
  input logic                 joypad2_data,
  input logic                 pal_write,
  input pal_entry_t           pal_entry
);

  logic byte_taken;

  // same acceptance rule as the download side of the palette
  assign byte_taken = palette_download & ioctl_wr & (ioctl_addr < DL_ADDR_W'(PAL_BYTES));

  pal_write_needs_download: assert property (
    @(posedge clk_ppu_21_47) !palette_download |-> !pal_write
  ) else $error("pal_write high while no palette download runs");

  ports_clear_after_reset: assert property (
    @(posedge clk_ppu_21_47) reset_nes |=> (!joypad1_data && !joypad2_data)
  ) else $error("joypad data not 0 in the cycle after reset");

  // mid-entry with no byte coming in
  entry_holds: assert property (
    @(posedge clk_ppu_21_47)
      (!reset_nes && palette_download && !pal_write && !byte_taken) |=> $stable(pal_entry)
  ) else $error("pal_entry moved without an accepted byte");

endmodule

bind nes_io_top nes_io_sva u_sva (
  .clk_ppu_21_47   (clk_ppu_21_47),
  .reset_nes       (reset_nes),
  .palette_download(palette_download),
  .ioctl_wr        (ioctl_wr),
  .ioctl_addr      (ioctl_addr),
  .joypad1_data    (joypad1_data),
  .joypad2_data    (joypad2_data),
  .pal_write       (pal_write),
  .pal_entry       (pal_entry)
);

// ==== tb/tb_nes_io_top.sv ====
`timescale 1ns/1ns

module tb_nes_io_top import nes_io_pkg::*; ();

  // one read of both ports and what it must return
  typedef struct {
    pad_array_t   pads;
    logic         swap;
    logic         multitap;
    turbo_speed_t speed;
    int           vsyncs;
    port_frame_t  exp1;
    port_frame_t  exp2;
  } row_t;

  logic                 clk_ppu_21_47;
  logic                 reset_nes;
  pad_array_t           pads;
  turbo_speed_t         turbo_speed;
  logic                 vsync;
  logic                 swap_controllers;
  logic                 multitap_enabled;
  logic                 joypad_strobe;
  logic [1:0]           joypad_clock;
  logic                 joypad1_data;
  logic                 joypad2_data;
  logic                 palette_download;
  logic                 ioctl_wr;
  logic [DL_ADDR_W-1:0] ioctl_addr;
  logic [7:0]           ioctl_dout;
  logic                 pal_write;
  pal_entry_t           pal_entry;

  integer     seed = 44022;
  row_t       rows[$];
  logic [7:0] pal_bytes [0:PAL_BYTES+5];

  nes_io_top u_dut (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .pads            (pads),
    .turbo_speed     (turbo_speed),
    .vsync           (vsync),
    .swap_controllers(swap_controllers),
    .multitap_enabled(multitap_enabled),
    .joypad_strobe   (joypad_strobe),
    .joypad_clock    (joypad_clock),
    .joypad1_data    (joypad1_data),
    .joypad2_data    (joypad2_data),
    .palette_download(palette_download),
    .ioctl_wr        (ioctl_wr),
    .ioctl_addr      (ioctl_addr),
    .ioctl_dout      (ioctl_dout),
    .pal_write       (pal_write),
    .pal_entry       (pal_entry)
  );

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #10 clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  // phase flips once every speed+1 frames
  function automatic logic turbo_phase(input int frames, input turbo_speed_t speed);
    int period;
    period = int'(speed) + 1;
    return ((frames / period) % 2) == 1;
  endfunction

  function automatic nes_report_t report_of(input pad_buttons_t p, input logic phase);
    nes_report_t r;
    r.right  = p.right;
    r.left   = p.left;
    r.down   = p.down;
    r.up     = p.up;
    r.start  = p.start;
    r.select = p.select;
    r.b      = p.b | (p.b_turbo & phase);
    r.a      = p.a | (p.a_turbo & phase);
    return r;
  endfunction

  function automatic port_frame_t expect_frame(input pad_array_t p, input logic swap,
                                               input logic mtap, input int port,
                                               input logic phase);
    port_frame_t f;
    int          first;
    first = (port == 1) ? (swap ? 1 : 0) : (swap ? 0 : 1);
    f[0] = report_of(p[first], phase);
    if (mtap) begin
      // player 3 behind port 1, player 4 behind port 2
      f[1] = report_of(p[port + 1], phase);
      f[2] = (port == 1) ? nes_report_t'(MULTITAP_SIG_PORT1) : nes_report_t'(MULTITAP_SIG_PORT2);
    end else begin
      f[2:1] = '1;
    end
    return f;
  endfunction

  function automatic row_t make_row(input pad_array_t p, input logic swap, input logic mtap,
                                    input turbo_speed_t speed, input int vsyncs);
    row_t r;
    logic phase;
    phase      = turbo_phase(vsyncs, speed);
    r.pads     = p;
    r.swap     = swap;
    r.multitap = mtap;
    r.speed    = speed;
    r.vsyncs   = vsyncs;
    r.exp1     = expect_frame(p, swap, mtap, 1, phase);
    r.exp2     = expect_frame(p, swap, mtap, 2, phase);
    return r;
  endfunction

  function automatic pad_array_t random_pads();
    logic [63:0] bits;
    bits = {$random(seed), $random(seed)};
    return pad_array_t'(bits[39:0]);
  endfunction

  // turbo held on every pad, plain a and b released
  function automatic pad_array_t turbo_pads();
    pad_array_t p;
    p = '0;
    for (int i = 0; i < PAD_COUNT; i++) begin
      p[i].a_turbo = 1'b1;
      p[i].b_turbo = (i != 2);
      p[i].start   = (i == 1);
      p[i].left    = (i == 3);
    end
    return p;
  endfunction

  function automatic pal_entry_t make_entry(input int group, input logic [7:0] r,
                                            input logic [7:0] g, input logic [7:0] b);
    pal_entry_t e;
    e.index = 6'(group);
    e.red   = r;
    e.green = g;
    e.blue  = b;
    return e;
  endfunction

  task automatic build_table();
    rows.push_back(make_row(pad_array_t'(40'h5a_c3a5_3c96), 1'b0, 1'b0, 3'd0, 0));
    rows.push_back(make_row(pad_array_t'(40'h5a_c3a5_3c96), 1'b1, 1'b0, 3'd0, 0));
    rows.push_back(make_row(pad_array_t'(40'h3c_96a5_5ac3), 1'b0, 1'b1, 3'd0, 0));
    rows.push_back(make_row(pad_array_t'(40'h3c_96a5_5ac3), 1'b1, 1'b1, 3'd0, 0));
    // turbo at several speeds, both phases
    rows.push_back(make_row(turbo_pads(), 1'b0, 1'b1, 3'd0, 1));
    rows.push_back(make_row(turbo_pads(), 1'b1, 1'b1, 3'd1, 3));
    rows.push_back(make_row(turbo_pads(), 1'b0, 1'b1, 3'd2, 7));
    rows.push_back(make_row(turbo_pads(), 1'b0, 1'b0, 3'd3, 2));
    rows.push_back(make_row(turbo_pads(), 1'b1, 1'b1, 3'd5, 6));
    rows.push_back(make_row(turbo_pads(), 1'b0, 1'b1, 3'd7, 16));
    for (int i = 0; i < 6; i++) begin
      rows.push_back(make_row(random_pads(), 1'($random(seed)), 1'($random(seed)),
                              3'($random(seed)), int'($unsigned($random(seed)) % 10)));
    end
  endtask

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_frame(input port_frame_t got, input port_frame_t exp,
                               input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_entry(input pal_entry_t got, input pal_entry_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic wait_pal_write(input string what);
    int cycles;
    cycles = 0;
    while (pal_write !== 1'b1 && cycles < 16) begin
      @(negedge clk_ppu_21_47);
      cycles++;
    end
    if (pal_write !== 1'b1) begin
      $display("Timeout at %0t: pal_write never rose after %s", $time, what);
      abort_run();
    end
  endtask

  task automatic pulse_vsync();
    vsync = 1'b1;
    repeat (2) @(negedge clk_ppu_21_47);
    vsync = 1'b0;
    repeat (2) @(negedge clk_ppu_21_47);
  endtask

  // latch, then one port clock pulse per bit
  task automatic read_ports(output port_frame_t got1, output port_frame_t got2);
    logic [23:0] bits1;
    logic [23:0] bits2;
    @(negedge clk_ppu_21_47);
    joypad_strobe = 1'b1;
    @(negedge clk_ppu_21_47);
    joypad_strobe = 1'b0;
    for (int i = 0; i < 24; i++) begin
      bits1[i] = joypad1_data;
      bits2[i] = joypad2_data;
      joypad_clock = 2'b11;
      @(negedge clk_ppu_21_47);
      joypad_clock = 2'b00;
      @(negedge clk_ppu_21_47);
    end
    got1 = port_frame_t'(bits1);
    got2 = port_frame_t'(bits2);
  endtask

  task automatic run_row(input row_t r, input int idx);
    port_frame_t got1;
    port_frame_t got2;
    // fresh reset so the turbo count starts from zero
    @(negedge clk_ppu_21_47);
    reset_nes        = 1'b1;
    pads             = r.pads;
    swap_controllers = r.swap;
    multitap_enabled = r.multitap;
    turbo_speed      = r.speed;
    repeat (2) @(negedge clk_ppu_21_47);
    reset_nes = 1'b0;
    repeat (r.vsyncs) pulse_vsync();
    read_ports(got1, got2);
    compare_frame(got1, r.exp1, $sformatf("row %0d port 1 frame", idx));
    compare_frame(got2, r.exp2, $sformatf("row %0d port 2 frame", idx));
    compare_bit(joypad1_data, 1'b0, $sformatf("row %0d port 1 after 24 shifts", idx));
    compare_bit(joypad2_data, 1'b0, $sformatf("row %0d port 2 after 24 shifts", idx));
  endtask

  task automatic write_byte(input int addr, input logic [7:0] value);
    @(negedge clk_ppu_21_47);
    ioctl_wr   = 1'b1;
    ioctl_addr = DL_ADDR_W'(addr);
    ioctl_dout = value;
    @(negedge clk_ppu_21_47);
    ioctl_wr = 1'b0;
    @(negedge clk_ppu_21_47);
  endtask

  task automatic load_palette();
    pal_entry_t last;
    for (int i = 0; i < PAL_BYTES + 6; i++) begin
      pal_bytes[i] = 8'($random(seed));
    end
    @(negedge clk_ppu_21_47);
    palette_download = 1'b1;
    for (int addr = 0; addr < PAL_BYTES; addr++) begin
      write_byte(addr, pal_bytes[addr]);
      if (addr % 3 == 2) begin
        wait_pal_write($sformatf("palette byte %0d", addr));
        last = make_entry(addr / 3, pal_bytes[addr-2], pal_bytes[addr-1], pal_bytes[addr]);
        compare_entry(pal_entry, last, $sformatf("palette entry %0d", addr / 3));
      end else begin
        compare_bit(pal_write, 1'b0, $sformatf("pal_write inside entry, byte %0d", addr));
      end
    end
    // bytes past the palette area must change nothing
    for (int addr = PAL_BYTES; addr < PAL_BYTES + 6; addr++) begin
      write_byte(addr, pal_bytes[addr]);
    end
    compare_bit(pal_write, 1'b1, "pal_write after bytes past the palette");
    compare_entry(pal_entry, last, "entry after bytes past the palette");
  endtask

  task automatic restart_palette();
    logic [7:0] fresh [0:5];
    for (int i = 0; i < 6; i++) begin
      fresh[i] = 8'($random(seed));
    end
    @(negedge clk_ppu_21_47);
    palette_download = 1'b0;
    repeat (2) @(negedge clk_ppu_21_47);
    compare_bit(pal_write, 1'b0, "pal_write with the download off");
    palette_download = 1'b1;
    for (int addr = 0; addr < 6; addr++) begin
      write_byte(addr, fresh[addr]);
      if (addr % 3 == 2) begin
        wait_pal_write($sformatf("restarted byte %0d", addr));
        compare_entry(pal_entry, make_entry(addr / 3, fresh[addr-2], fresh[addr-1], fresh[addr]),
                      $sformatf("restarted entry %0d", addr / 3));
      end
    end
    @(negedge clk_ppu_21_47);
    palette_download = 1'b0;
  endtask

  initial begin
    reset_nes        = 1'b1;
    pads             = '0;
    turbo_speed      = '0;
    vsync            = 1'b0;
    swap_controllers = 1'b0;
    multitap_enabled = 1'b0;
    joypad_strobe    = 1'b0;
    joypad_clock     = 2'b00;
    palette_download = 1'b0;
    ioctl_wr         = 1'b0;
    ioctl_addr       = '0;
    ioctl_dout       = '0;
    build_table();
    repeat (10) @(negedge clk_ppu_21_47);
    reset_nes = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      run_row(rows[i], i);
    end
    load_palette();
    restart_palette();
    repeat (2) @(negedge clk_ppu_21_47);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
src/nes_io_pkg.sv
src/button_turbo.sv
src/joypad_port.sv
src/controller_hub.sv
src/palette_loader.sv
src/nes_io_top.sv
tb/nes_io_sva.sv
tb/tb_nes_io_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_nes_io_top \
  -f tb.f \
  -Mdir obj_dir \
  -o sim_nes_io
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_nes_io
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi

exit 0
